/* src/mipsPkg.sv */
`default_nettype none

package mipsPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0] cregAddrT;

    // Operand source chosen by the hazard unit
    typedef enum logic [1:0] {
        NOFORWARD,
        ALUOUTM,
        RESULTW
    } forwardT;

    // Anything outside the subset decodes to NOP
    typedef enum logic [3:0] {
        NOP,
        ADDU,
        SUBU,
        OR,
        SLT,
        ADDIU,
        LW,
        SW,
        BEQ,
        BNE,
        JR
    } decodedOpT;

    typedef struct packed {
        logic regWrite;
        logic memRead;
        logic memWrite;
        logic branch;
        logic jr;
        logic aluSrcImm;
    } ctlT;

endpackage

`default_nettype wire

/* src/decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  mipsPkg::wordT      instr,
    output mipsPkg::decodedOpT op,
    output mipsPkg::ctlT       ctl,
    output mipsPkg::cregAddrT  rs,
    output mipsPkg::cregAddrT  rt,
    output mipsPkg::cregAddrT  writeReg,
    output mipsPkg::wordT      imm
);
    import mipsPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    cregAddrT rd;

    assign opcode = instr[31:26];
    assign funct = instr[5:0];
    assign rs = instr[25:21];
    assign rt = instr[20:16];
    assign rd = instr[15:11];
    assign imm = {{16{instr[15]}}, instr[15:0]};

    always_comb begin
        op = NOP;
        case (opcode)
            6'h00: begin
                case (funct)
                    6'h21: op = ADDU;
                    6'h23: op = SUBU;
                    6'h25: op = OR;
                    6'h2a: op = SLT;
                    6'h08: op = JR;
                    default: op = NOP;
                endcase
            end
            6'h09: op = ADDIU;
            6'h23: op = LW;
            6'h2b: op = SW;
            6'h04: op = BEQ;
            6'h05: op = BNE;
            default: op = NOP;
        endcase
    end

    always_comb begin
        ctl = '0;
        writeReg = '0;
        case (op)
            ADDU, SUBU, OR, SLT: begin
                writeReg = rd;
                ctl.regWrite = (rd != 0);
            end
            ADDIU: begin
                writeReg = rt;
                ctl.regWrite = (rt != 0);
                ctl.aluSrcImm = 1'b1;
            end
            LW: begin
                writeReg = rt;
                ctl.regWrite = (rt != 0);
                ctl.memRead = 1'b1;
                ctl.aluSrcImm = 1'b1;
            end
            SW: begin
                ctl.memWrite = 1'b1;
                ctl.aluSrcImm = 1'b1;
            end
            BEQ, BNE: ctl.branch = 1'b1;
            JR: ctl.jr = 1'b1;
            default: ctl = '0;
        endcase
    end

endmodule

`default_nettype wire

/* src/hazard.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard (
    input  mipsPkg::cregAddrT  rsD,
    input  mipsPkg::cregAddrT  rtD,
    input  mipsPkg::decodedOpT opD,
    input  logic               branchD,
    input  logic               jrD,
    input  mipsPkg::cregAddrT  rsE,
    input  mipsPkg::cregAddrT  rtE,
    input  mipsPkg::cregAddrT  writeRegE,
    input  logic               regWriteE,
    input  logic               memReadE,
    input  mipsPkg::cregAddrT  writeRegM,
    input  logic               regWriteM,
    input  logic               memReadM,
    input  mipsPkg::cregAddrT  writeRegW,
    input  logic               regWriteW,
    input  logic               fetchOk,
    output logic               stallF,
    output logic               stallD,
    output logic               flushE,
    output mipsPkg::forwardT   forwardAD,
    output mipsPkg::forwardT   forwardBD,
    output mipsPkg::forwardT   forwardAE,
    output mipsPkg::forwardT   forwardBE
);
    import mipsPkg::*;

    logic loadUseStall;
    logic branchStall;
    logic cmpBranch;
    logic rsBusy;
    logic rtBusy;

    // Memory stage wins over writeback, register 0 never forwards
    function automatic forwardT pickSource(
        cregAddrT src,
        cregAddrT regM,
        logic     wrM,
        cregAddrT regW,
        logic     wrW
    );
        if (src == 0) begin
            return NOFORWARD;
        end else if (wrM && src == regM) begin
            return ALUOUTM;
        end else if (wrW && src == regW) begin
            return RESULTW;
        end
        return NOFORWARD;
    endfunction

    assign forwardAD = pickSource(rsD, writeRegM, regWriteM, writeRegW, regWriteW);
    assign forwardBD = pickSource(rtD, writeRegM, regWriteM, writeRegW, regWriteW);
    assign forwardAE = pickSource(rsE, writeRegM, regWriteM, writeRegW, regWriteW);
    assign forwardBE = pickSource(rtE, writeRegM, regWriteM, writeRegW, regWriteW);

    assign loadUseStall = memReadE && (writeRegE != 0) &&
                          ((rsD == writeRegE) || (rtD == writeRegE));

    // A decode-stage compare needs its operands already out of execute
    // and out of a pending load
    assign cmpBranch = (opD == BEQ) || (opD == BNE);
    assign rsBusy = (rsD != 0) &&
                    ((regWriteE && writeRegE == rsD) || (memReadM && writeRegM == rsD));
    assign rtBusy = (rtD != 0) && cmpBranch &&
                    ((regWriteE && writeRegE == rtD) || (memReadM && writeRegM == rtD));
    assign branchStall = (branchD || jrD) && (rsBusy || rtBusy);

    assign stallF = loadUseStall | branchStall | ~fetchOk;
    assign stallD = stallF;
    assign flushE = stallF;

endmodule

`default_nettype wire

/* src/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic              clk,
    input  logic              rstN,
    input  mipsPkg::cregAddrT ra1,
    input  mipsPkg::cregAddrT ra2,
    input  mipsPkg::cregAddrT wa,
    input  logic              we,
    input  mipsPkg::wordT     wd,
    output mipsPkg::wordT     rd1,
    output mipsPkg::wordT     rd2
);
    import mipsPkg::*;

    wordT regs [32];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != 0) begin
            regs[wa] <= wd;
        end
    end

    // Same-cycle write is visible to decode
    assign rd1 = (ra1 == 0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (ra2 == 0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

endmodule

`default_nettype wire

/* src/mipsCore.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsCore (
    input  logic              clk,
    input  logic              rstN,
    output mipsPkg::wordT     fetchAddr,
    input  mipsPkg::wordT     fetchData,
    output logic              dataReq,
    output logic              dataWe,
    output mipsPkg::wordT     dataAddr,
    output mipsPkg::wordT     dataWdata,
    input  mipsPkg::wordT     dataRdata,
    input  logic              fetchOk,
    output logic              retireValid,
    output mipsPkg::cregAddrT retireReg,
    output mipsPkg::wordT     retireData,
    output logic              storeValid,
    output mipsPkg::wordT     storeAddr,
    output mipsPkg::wordT     storeData
);
    import mipsPkg::*;

    wordT pc, pcNext;
    wordT instrD, pcPlus4D, immD, rd1D, rd2D, aD, bD;
    decodedOpT opD;
    ctlT ctlD;
    cregAddrT rsD, rtD, writeRegD;
    logic takenD;

    decodedOpT opE;
    ctlT ctlE;
    cregAddrT rsE, rtE, writeRegE;
    wordT rd1E, rd2E, immE, srcAE, srcBE, writeDataE, aluOutE;

    ctlT ctlM;
    cregAddrT writeRegM;
    wordT aluOutM, writeDataM;

    ctlT ctlW;
    cregAddrT writeRegW;
    wordT aluOutW, readDataW, resultW;

    logic stallF, stallD, flushE;
    forwardT forwardAD, forwardBD, forwardAE, forwardBE;

    function automatic wordT pickOperand(forwardT sel, wordT regVal, wordT aluOut, wordT result);
        case (sel)
            ALUOUTM: return aluOut;
            RESULTW: return result;
            default: return regVal;
        endcase
    endfunction

    // Fetch
    assign fetchAddr = pc;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else if (!stallF) begin
            pc <= pcNext;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            instrD <= '0;
        end else if (!stallD) begin
            instrD <= fetchData;
            pcPlus4D <= pc + 32'd4;
        end
    end

    // Decode and branch resolution
    decoder uDecoder (
        .instr(instrD), .op(opD), .ctl(ctlD),
        .rs(rsD), .rt(rtD), .writeReg(writeRegD), .imm(immD)
    );

    regFile uRegFile (
        .clk(clk), .rstN(rstN), .ra1(rsD), .ra2(rtD),
        .wa(writeRegW), .we(ctlW.regWrite), .wd(resultW), .rd1(rd1D), .rd2(rd2D)
    );

    assign aD = pickOperand(forwardAD, rd1D, aluOutM, resultW);
    assign bD = pickOperand(forwardBD, rd2D, aluOutM, resultW);
    assign takenD = (opD == BEQ && aD == bD) || (opD == BNE && aD != bD);

    // pc already points at the delay slot here
    always_comb begin
        if (ctlD.jr) begin
            pcNext = aD;
        end else if (takenD) begin
            pcNext = pcPlus4D + {immD[29:0], 2'b00};
        end else begin
            pcNext = pc + 32'd4;
        end
    end

    hazard uHazard (
        .rsD(rsD), .rtD(rtD), .opD(opD), .branchD(ctlD.branch), .jrD(ctlD.jr),
        .rsE(rsE), .rtE(rtE), .writeRegE(writeRegE),
        .regWriteE(ctlE.regWrite), .memReadE(ctlE.memRead),
        .writeRegM(writeRegM), .regWriteM(ctlM.regWrite), .memReadM(ctlM.memRead),
        .writeRegW(writeRegW), .regWriteW(ctlW.regWrite), .fetchOk(fetchOk),
        .stallF(stallF), .stallD(stallD), .flushE(flushE),
        .forwardAD(forwardAD), .forwardBD(forwardBD),
        .forwardAE(forwardAE), .forwardBE(forwardBE)
    );

    // Execute
    always_ff @(posedge clk) begin
        if (!rstN || flushE) begin
            opE <= NOP;
            ctlE <= '0;
            rsE <= '0;
            rtE <= '0;
            writeRegE <= '0;
        end else begin
            opE <= opD;
            ctlE <= ctlD;
            rsE <= rsD;
            rtE <= rtD;
            writeRegE <= writeRegD;
        end
        rd1E <= rd1D;
        rd2E <= rd2D;
        immE <= immD;
    end

    assign srcAE = pickOperand(forwardAE, rd1E, aluOutM, resultW);
    assign writeDataE = pickOperand(forwardBE, rd2E, aluOutM, resultW);
    assign srcBE = ctlE.aluSrcImm ? immE : writeDataE;

    always_comb begin
        case (opE)
            SUBU: aluOutE = srcAE - srcBE;
            OR: aluOutE = srcAE | srcBE;
            SLT: aluOutE = {31'b0, $signed(srcAE) < $signed(srcBE)};
            default: aluOutE = srcAE + srcBE;
        endcase
    end

    // Memory
    always_ff @(posedge clk) begin
        if (!rstN) begin
            ctlM <= '0;
            writeRegM <= '0;
        end else begin
            ctlM <= ctlE;
            writeRegM <= writeRegE;
        end
        aluOutM <= aluOutE;
        writeDataM <= writeDataE;
    end

    assign dataReq = ctlM.memRead | ctlM.memWrite;
    assign dataWe = ctlM.memWrite;
    assign dataAddr = aluOutM;
    assign dataWdata = writeDataM;

    assign storeValid = ctlM.memWrite;
    assign storeAddr = aluOutM;
    assign storeData = writeDataM;

    // Writeback
    always_ff @(posedge clk) begin
        if (!rstN) begin
            ctlW <= '0;
            writeRegW <= '0;
        end else begin
            ctlW <= ctlM;
            writeRegW <= writeRegM;
        end
        aluOutW <= aluOutM;
        readDataW <= dataRdata;
    end

    assign resultW = ctlW.memRead ? readDataW : aluOutW;

    assign retireValid = ctlW.regWrite;
    assign retireReg = writeRegW;
    assign retireData = resultW;

endmodule

`default_nettype wire

/* src/memArbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module memArbiter #(
    parameter int memWords = 1024
) (
    input  logic                        progWe,
    input  logic [$clog2(memWords)-1:0] progAddr,
    input  mipsPkg::wordT               progData,
    input  mipsPkg::wordT               fetchAddr,
    output mipsPkg::wordT               fetchData,
    input  logic                        dataReq,
    input  logic                        dataWe,
    input  mipsPkg::wordT               dataAddr,
    input  mipsPkg::wordT               dataWdata,
    output mipsPkg::wordT               dataRdata,
    output logic                        fetchOk,
    output logic                        memWe,
    output logic [$clog2(memWords)-1:0] memAddr,
    output mipsPkg::wordT               memWdata,
    input  mipsPkg::wordT               memRdata
);
    localparam int addrW = $clog2(memWords);

    // Loader first, then the memory stage, fetch gets what is left
    always_comb begin
        memWe = 1'b0;
        memWdata = dataWdata;
        fetchOk = 1'b0;
        if (progWe) begin
            memWe = 1'b1;
            memAddr = progAddr;
            memWdata = progData;
        end else if (dataReq) begin
            memWe = dataWe;
            memAddr = dataAddr[addrW+1:2];
        end else begin
            memAddr = fetchAddr[addrW+1:2];
            fetchOk = 1'b1;
        end
    end

    assign fetchData = memRdata;
    assign dataRdata = memRdata;

endmodule

`default_nettype wire

/* src/unifiedMem.sv */
`timescale 1ns/1ps
`default_nettype none

module unifiedMem #(
    parameter int memWords = 1024
) (
    input  logic                        clk,
    input  logic                        we,
    input  logic [$clog2(memWords)-1:0] addr,
    input  mipsPkg::wordT               wdata,
    output mipsPkg::wordT               rdata
);
    import mipsPkg::*;

    wordT mem [memWords];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // Read is combinational so a granted access finishes in its cycle
    assign rdata = mem[addr];

endmodule

`default_nettype wire

/* src/mipsTop.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsTop #(
    parameter int memWords = 1024
) (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        progWe,
    input  logic [$clog2(memWords)-1:0] progAddr,
    input  mipsPkg::wordT               progData,
    output logic                        retireValid,
    output mipsPkg::cregAddrT           retireReg,
    output mipsPkg::wordT               retireData,
    output logic                        storeValid,
    output mipsPkg::wordT               storeAddr,
    output mipsPkg::wordT               storeData
);
    import mipsPkg::*;

    wordT fetchAddr, fetchData, dataAddr, dataWdata, dataRdata;
    wordT memWdata, memRdata;
    logic dataReq, dataWe, fetchOk, memWe;
    logic [$clog2(memWords)-1:0] memAddr;

    mipsCore uCore (
        .clk(clk), .rstN(rstN),
        .fetchAddr(fetchAddr), .fetchData(fetchData),
        .dataReq(dataReq), .dataWe(dataWe), .dataAddr(dataAddr),
        .dataWdata(dataWdata), .dataRdata(dataRdata), .fetchOk(fetchOk),
        .retireValid(retireValid), .retireReg(retireReg), .retireData(retireData),
        .storeValid(storeValid), .storeAddr(storeAddr), .storeData(storeData)
    );

    memArbiter #(.memWords(memWords)) uArbiter (
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .fetchAddr(fetchAddr), .fetchData(fetchData),
        .dataReq(dataReq), .dataWe(dataWe), .dataAddr(dataAddr),
        .dataWdata(dataWdata), .dataRdata(dataRdata), .fetchOk(fetchOk),
        .memWe(memWe), .memAddr(memAddr), .memWdata(memWdata), .memRdata(memRdata)
    );

    unifiedMem #(.memWords(memWords)) uMem (
        .clk(clk), .we(memWe), .addr(memAddr), .wdata(memWdata), .rdata(memRdata)
    );

endmodule

`default_nettype wire

/* verification/tbMipsTop.sv */
`timescale 1ns/1ps
`default_nettype none

module tbMipsTop;
    import mipsPkg::*;

    localparam int memWords = 1024;
    localparam int addrW = $clog2(memWords);
    localparam int bodyLen = 40;
    localparam int loopIdx = 43;
    localparam int codeLen = 45;
    localparam int dataBase = 512;
    localparam int dataWords = 16;
    localparam int waitLimit = 400;
    localparam int runLimit = 3000;
    localparam int quietCycles = 100;
    localparam int numTests = 24;

    localparam int kindAlu = 0;
    localparam int kindAddiu = 1;
    localparam int kindLoad = 2;
    localparam int kindStore = 3;
    localparam int kindBranch = 4;

    logic clk;
    logic rstN;
    logic progWe;
    logic [addrW-1:0] progAddr;
    wordT progData;
    logic retireValid;
    cregAddrT retireReg;
    wordT retireData;
    logic storeValid;
    wordT storeAddr;
    wordT storeData;

    integer seed;
    int errorCount;
    int failedTests;
    int retIdx;
    int stIdx;
    wordT prog [codeLen];
    wordT modelMem [memWords];
    wordT modelRegs [32];
    int expRetReg [$];
    wordT expRetData [$];
    wordT expStAddr [$];
    wordT expStData [$];

    mipsTop #(.memWords(memWords)) uut (
        .clk(clk), .rstN(rstN),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .retireValid(retireValid), .retireReg(retireReg), .retireData(retireData),
        .storeValid(storeValid), .storeAddr(storeAddr), .storeData(storeData)
    );

    always #2 clk = ~clk;

    task automatic checkValue(input string name, input wordT got, input wordT exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            errorCount++;
        end
    endtask

    function automatic int randBelow(int n);
        return int'({$random(seed)} % n);
    endfunction

    function automatic int randReg();
        return 1 + randBelow(7);
    endfunction

    function automatic wordT encodeR(logic [5:0] funct, int rs, int rt, int rd);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'h00, funct};
    endfunction

    function automatic wordT encodeI(logic [5:0] opcode, int rs, int rt, int imm);
        return {opcode, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    // Data words get a value tied to their full address
    function automatic wordT fillWord(int idx);
        return (wordT'(idx) * 32'h9e3779b1) ^ 32'h0f1e2d3c;
    endfunction

    function automatic string modeName(int mode);
        case (mode)
            0: return "alu chain";
            1: return "load use";
            2: return "branches";
            3: return "loads and stores";
            default: return "random mix";
        endcase
    endfunction

    function automatic int pickKind(int mode, int idx, int afterBranch);
        int r;
        int kind;
        r = randBelow(100);
        case (mode)
            0: kind = (r < 70) ? kindAlu : kindAddiu;
            1: kind = (r < 45) ? kindLoad : ((r < 85) ? kindAlu : kindAddiu);
            2: kind = (r < 30) ? kindBranch : ((r < 45) ? kindLoad :
                      ((r < 80) ? kindAlu : kindAddiu));
            3: kind = (r < 35) ? kindLoad : ((r < 70) ? kindStore :
                      ((r < 85) ? kindAlu : kindAddiu));
            default: kind = (r < 15) ? kindBranch : ((r < 35) ? kindLoad :
                      ((r < 50) ? kindStore : ((r < 80) ? kindAlu : kindAddiu)));
        endcase
        // No branch inside a delay slot, and none at the last body slot
        if (kind == kindBranch && (afterBranch != 0 || idx >= bodyLen - 1)) begin
            kind = kindAddiu;
        end
        return kind;
    endfunction

    task automatic genProgram(input int mode);
        int prevDest;
        int afterBranch;
        int kind;
        int srcA;
        int srcB;
        int dest;
        int span;
        int offset;
        logic [5:0] funct;
        prevDest = 0;
        afterBranch = 0;
        for (int i = 0; i < bodyLen; i++) begin
            kind = pickKind(mode, i, afterBranch);
            srcA = randReg();
            srcB = randReg();
            dest = randReg();
            if (prevDest != 0 && (mode == 1 || randBelow(2) == 0)) begin
                srcA = prevDest;
            end
            offset = dataBase * 4 + 4 * randBelow(dataWords);
            afterBranch = 0;
            case (kind)
                kindAlu: begin
                    case (randBelow(4))
                        0: funct = 6'h21;
                        1: funct = 6'h23;
                        2: funct = 6'h25;
                        default: funct = 6'h2a;
                    endcase
                    prog[i] = encodeR(funct, srcA, srcB, dest);
                    prevDest = dest;
                end
                kindAddiu: begin
                    prog[i] = encodeI(6'h09, srcA, dest, randBelow(16) - 8);
                    prevDest = dest;
                end
                kindLoad: begin
                    prog[i] = encodeI(6'h23, 0, dest, offset);
                    prevDest = dest;
                end
                kindStore: begin
                    prog[i] = encodeI(6'h2b, 0, srcA, offset);
                end
                default: begin
                    span = (bodyLen - 1 - i < 4) ? bodyLen - 1 - i : 4;
                    funct = (randBelow(2) == 0) ? 6'h04 : 6'h05;
                    prog[i] = encodeI(funct, srcA, srcB, 1 + randBelow(span));
                    afterBranch = 1;
                end
            endcase
        end
        // Tail jumps through r1 to a branch that loops on itself
        prog[40] = encodeI(6'h09, 0, 1, loopIdx * 4);
        prog[41] = encodeR(6'h08, 1, 0, 0);
        prog[42] = '0;
        prog[43] = encodeI(6'h04, 0, 0, -1);
        prog[44] = '0;
    endtask

    task automatic recordWrite(input int r, input wordT v);
        if (r != 0) begin
            modelRegs[r] = v;
            expRetReg.push_back(r);
            expRetData.push_back(v);
        end
    endtask

    task automatic runModel();
        int pcIdx;
        int nextIdx;
        int newNext;
        int steps;
        int rs;
        int rt;
        int rd;
        wordT w;
        wordT a;
        wordT b;
        wordT immS;
        wordT addr;
        for (int r = 0; r < 32; r++) begin
            modelRegs[r] = '0;
        end
        expRetReg.delete();
        expRetData.delete();
        expStAddr.delete();
        expStData.delete();
        pcIdx = 0;
        nextIdx = 1;
        steps = 0;
        while (pcIdx != loopIdx && steps < 200) begin
            w = modelMem[pcIdx];
            rs = int'(w[25:21]);
            rt = int'(w[20:16]);
            rd = int'(w[15:11]);
            a = modelRegs[rs];
            b = modelRegs[rt];
            immS = {{16{w[15]}}, w[15:0]};
            addr = a + immS;
            newNext = nextIdx + 1;
            if (w[31:26] == 6'h00) begin
                case (w[5:0])
                    6'h21: recordWrite(rd, a + b);
                    6'h23: recordWrite(rd, a - b);
                    6'h25: recordWrite(rd, a | b);
                    6'h2a: recordWrite(rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                    6'h08: newNext = int'(a >> 2);
                    default: ;
                endcase
            end else begin
                case (w[31:26])
                    6'h09: recordWrite(rt, addr);
                    6'h23: recordWrite(rt, modelMem[addr[addrW+1:2]]);
                    6'h2b: begin
                        modelMem[addr[addrW+1:2]] = b;
                        expStAddr.push_back(addr);
                        expStData.push_back(b);
                    end
                    // Target counts from the delay slot
                    6'h04: if (a == b) newNext = nextIdx + int'($signed(immS));
                    6'h05: if (a != b) newNext = nextIdx + int'($signed(immS));
                    default: ;
                endcase
            end
            pcIdx = nextIdx;
            nextIdx = newNext;
            steps++;
        end
    endtask

    task automatic checkQuiet();
        @(negedge clk);
        checkValue("retireValid", 32'(retireValid), '0);
        checkValue("storeValid", 32'(storeValid), '0);
    endtask

    task automatic writeWord(input int idx, input wordT data);
        @(posedge clk);
        progWe <= 1'b1;
        progAddr <= addrW'(idx);
        progData <= data;
        checkQuiet();
    endtask

    task automatic loadProgram();
        @(posedge clk);
        rstN <= 1'b0;
        for (int c = 0; c < 16; c++) begin
            checkQuiet();
        end
        for (int i = 0; i < codeLen; i++) begin
            writeWord(i, prog[i]);
        end
        for (int i = dataBase; i < dataBase + dataWords; i++) begin
            writeWord(i, fillWord(i));
        end
        @(posedge clk);
        progWe <= 1'b0;
        checkQuiet();
        @(posedge clk);
        rstN <= 1'b1;
    endtask

    task automatic sampleEvents(output bit seen);
        seen = 1'b0;
        @(negedge clk);
        if (retireValid) begin
            seen = 1'b1;
            if (retIdx < expRetReg.size()) begin
                checkValue("retireReg", 32'(retireReg), expRetReg[retIdx]);
                checkValue("retireData", retireData, expRetData[retIdx]);
            end else begin
                $display("Unexpected retirement of r%0d at %0t ns after all %0d expected",
                         retireReg, $time, expRetReg.size());
                errorCount++;
            end
            retIdx++;
        end
        if (storeValid) begin
            seen = 1'b1;
            if (stIdx < expStAddr.size()) begin
                checkValue("storeAddr", storeAddr, expStAddr[stIdx]);
                checkValue("storeData", storeData, expStData[stIdx]);
            end else begin
                $display("Unexpected store to %h at %0t ns after all %0d expected",
                         storeAddr, $time, expStAddr.size());
                errorCount++;
            end
            stIdx++;
        end
    endtask

    task automatic runTest(input int num, input int mode);
        int errBefore;
        int idle;
        int cycles;
        bit seen;
        errBefore = errorCount;
        genProgram(mode);
        for (int i = 0; i < codeLen; i++) begin
            modelMem[i] = prog[i];
        end
        for (int i = dataBase; i < dataBase + dataWords; i++) begin
            modelMem[i] = fillWord(i);
        end
        runModel();
        loadProgram();
        retIdx = 0;
        stIdx = 0;
        idle = 0;
        cycles = 0;
        while ((retIdx < expRetReg.size() || stIdx < expStAddr.size()) &&
               idle < waitLimit && cycles < runLimit) begin
            sampleEvents(seen);
            idle = seen ? 0 : idle + 1;
            cycles++;
        end
        if (retIdx < expRetReg.size()) begin
            $display("Timeout: retirement %0d of %0d (r%0d) never arrived",
                     retIdx + 1, expRetReg.size(), expRetReg[retIdx]);
            errorCount++;
        end
        if (stIdx < expStAddr.size()) begin
            $display("Timeout: store %0d of %0d (address %h) never arrived",
                     stIdx + 1, expStAddr.size(), expStAddr[stIdx]);
            errorCount++;
        end
        // Pipeline should now spin in the self loop without events
        for (int c = 0; c < quietCycles; c++) begin
            sampleEvents(seen);
        end
        if (errorCount != errBefore) begin
            failedTests++;
        end
        $display("Test %0d (%s): %0d retirements, %0d stores, %s", num, modeName(mode),
                 expRetReg.size(), expStAddr.size(), (errorCount == errBefore) ? "ok" : "failed");
    endtask

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        progWe = 1'b0;
        progAddr = '0;
        progData = '0;
        seed = 32'h9fb3;
        errorCount = 0;
        failedTests = 0;
        for (int t = 0; t < 4; t++) begin
            runTest(t, t);
        end
        for (int t = 4; t < numTests; t++) begin
            runTest(t, 4);
        end
        $display("%0d tests run, %0d failed, %0d errors", numTests, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
src/mipsPkg.sv
src/decoder.sv
src/hazard.sv
src/regFile.sv
src/mipsCore.sv
src/memArbiter.sv
src/unifiedMem.sv
src/mipsTop.sv
verification/tbMipsTop.sv

/* Makefile */
TOP = tbMipsTop

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal --top-module $(TOP) -f tb.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir
